/* source/mul_defines.svh */
/*
  Vector multiply unit sizes
  Vector, scalar and tag widths plus the lane and tile geometry of the 8x8 array.
*/
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// register widths
`define MUL_VLEN    128
`define MUL_VLENB   16
`define MUL_XLEN    32

// reorder buffer tag
`define MUL_TAG_W   4

// partial product array
`define MUL_LANES   16   // 8-bit input lanes per operand
`define MUL_TILE_N  4    // edge of one tile group
`define MUL_PARTS   64   // 4 groups of 4x4 tiles
`define MUL_PART_W  16

`endif

/* source/mul_pkg.sv */
/*
  Vector multiply unit types
  Opcode, element width and rounding enums, the per-uop control word and
  the vector typedefs used across the pipeline.
*/
`include "mul_defines.svh"

package mul_pkg;

  typedef enum logic [2:0] {
    MUL_LOW     = 3'd0,
    MUL_HIGH_SS = 3'd1,
    MUL_HIGH_UU = 3'd2,
    MUL_HIGH_SU = 3'd3,
    MUL_SMUL    = 3'd4   // other codes act as MUL_LOW
  } mul_op_e;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2         // code 3 acts as EEW8
  } mul_eew_e;

  typedef enum logic [1:0] {
    RNU = 2'd0,
    RNE = 2'd1,
    RDN = 2'd2,
    ROD = 2'd3
  } mul_xrm_e;

  typedef logic [`MUL_VLEN-1:0]   vreg_t;
  typedef logic [`MUL_XLEN-1:0]   xreg_t;
  typedef logic [`MUL_TAG_W-1:0]  tag_t;
  typedef logic [`MUL_VLENB-1:0]  vsat_t;
  typedef logic [`MUL_PART_W-1:0] part_t;

  typedef struct packed {
    mul_op_e  op;
    mul_eew_e eew;
    mul_xrm_e xrm;
    tag_t     tag;
  } mul_ctrl_t;

  // {vs2 signed, src1 signed} for an opcode
  function automatic logic [1:0] op_signs(mul_op_e op);
    case (op)
      MUL_HIGH_UU: return 2'b00;
      MUL_HIGH_SU: return 2'b10;
      default:     return 2'b11;
    endcase
  endfunction

endpackage

/* source/mul_stage_if.sv */
/*
  Stage boundaries of the multiply pipeline
  mul_op_if carries decoded operands into the tile array, mul_prod_if carries
  the registered partial products into the result stage.
*/
`timescale 1ns/1ps
`include "mul_defines.svh"

interface mul_op_if import mul_pkg::*; ();

  logic                  valid;
  mul_ctrl_t             ctrl;
  vreg_t                 src2;
  vreg_t                 src1;
  logic [`MUL_LANES-1:0] sign2;   // lane holds a signed top byte
  logic [`MUL_LANES-1:0] sign1;

  modport decode (
    output valid, ctrl, src2, src1, sign2, sign1
  );

  modport array (
    input  valid, ctrl, src2, src1, sign2, sign1
  );

endinterface

interface mul_prod_if import mul_pkg::*; ();

  logic                        valid;
  mul_ctrl_t                   ctrl;
  part_t [`MUL_PARTS-1:0]      parts;   // z*16 + y*4 + x

  modport array (
    output valid, ctrl, parts
  );

  modport result (
    input  valid, ctrl, parts
  );

endinterface

/* source/mul_decode.sv */
/*
  Multiply decode
  Maps the opcode to operand signedness, replicates the scalar for the .vx form
  and marks which 8-bit lanes carry the sign of their element.
*/
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_decode import mul_pkg::*; (
  input  logic     valid,
  input  mul_op_e  op,
  input  mul_eew_e eew,
  input  mul_xrm_e xrm,
  input  logic     scalar,   // 1 selects the vector-scalar form
  input  vreg_t    vs2,
  input  vreg_t    vs1,
  input  xreg_t    rs1,
  input  tag_t     tag,
  mul_op_if.decode dec
);

  logic                  src2_signed;
  logic                  src1_signed;
  logic [`MUL_LANES-1:0] msb_lanes;   // top byte lane of each element
  vreg_t                 rs1_rep;

  assign {src2_signed, src1_signed} = op_signs(op);

  //////////////////////////////
  // element layout per eew
  //////////////////////////////

  always_comb begin
    case (eew)
      EEW16: begin
        msb_lanes = {8{2'b10}};
        rs1_rep   = {8{rs1[15:0]}};
      end
      EEW32: begin
        msb_lanes = {4{4'b1000}};
        rs1_rep   = {4{rs1}};
      end
      default: begin                  // EEW8 and the spare code
        msb_lanes = {`MUL_LANES{1'b1}};
        rs1_rep   = {16{rs1[7:0]}};
      end
    endcase
  end

  //////////////////////////////
  // drive the array stage
  //////////////////////////////

  assign dec.valid = valid;
  assign dec.ctrl  = '{op: op, eew: eew, xrm: xrm, tag: tag};
  assign dec.src2  = vs2;
  assign dec.src1  = scalar ? rs1_rep : vs1;   // scalar copied into every element
  assign dec.sign2 = msb_lanes & {`MUL_LANES{src2_signed}};
  assign dec.sign1 = msb_lanes & {`MUL_LANES{src1_signed}};

endmodule

/* source/mul_array.sv */
/*
  Multiply tile array
  Four groups of 4x4 signed/unsigned 8x8 multipliers, followed by the single
  pipeline register for partial products, control and valid.
*/
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_array import mul_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  mul_op_if.array   opr,
  mul_prod_if.array prod
);

  localparam int TN     = `MUL_TILE_N;
  localparam int GROUPS = `MUL_LANES / `MUL_TILE_N;

  part_t [`MUL_PARTS-1:0] part;   // tile outputs before the register

  //////////////////////////////
  // 8x8 tiles
  //////////////////////////////

  for (genvar z = 0; z < GROUPS; z++) begin : g_grp
    for (genvar x = 0; x < TN; x++) begin : g_x
      for (genvar y = 0; y < TN; y++) begin : g_y
        localparam int LA = z*TN + x;           // vs2 lane
        localparam int LB = z*TN + y;           // src1 lane
        localparam int P  = z*TN*TN + y*TN + x;

        logic signed [8:0]  a;
        logic signed [8:0]  b;
        logic signed [17:0] pp;

        // one extra bit carries the lane sign or a zero
        assign a = {opr.sign2[LA] & opr.src2[8*LA+7], opr.src2[8*LA +: 8]};
        assign b = {opr.sign1[LB] & opr.src1[8*LB+7], opr.src1[8*LB +: 8]};
        assign pp = a * b;
        assign part[P] = pp[15:0];   // any sign mix fits in 16 bits
      end
    end
  end

  //////////////////////////////
  // pipeline register
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod.valid <= 1'b0;
    end else begin
      prod.valid <= opr.valid;
    end
  end

  always_ff @(posedge clk) begin
    prod.parts <= part;
    prod.ctrl  <= opr.ctrl;
  end

endmodule

/* source/mul_result.sv */
/*
  Multiply result stage
  Builds the 16/32/64-bit element products from the registered tiles, picks
  the low or high half, and does vsmul rounding and saturation.
*/
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_result import mul_pkg::*; (
  mul_prod_if.result prod,
  output logic       out_valid,
  output tag_t       out_tag,
  output vreg_t      out_data,
  output vsat_t      out_vsat
);

  localparam int TN     = `MUL_TILE_N;
  localparam int GROUPS = `MUL_LANES / `MUL_TILE_N;

  logic  s2;   // vs2 signed
  logic  s1;   // src1 signed
  vreg_t data8;
  vreg_t data16;
  vreg_t data32;
  vsat_t sat8;
  vsat_t sat16;
  vsat_t sat32;

  // sum the tiles of one element of nb bytes starting at lane base of group z
  function automatic logic [63:0] elem_prod(part_t [`MUL_PARTS-1:0] p, int z,
                                            int base, int nb, logic sg2, logic sg1);
    logic [63:0] acc;
    logic [63:0] term;
    logic        ext;
    acc = '0;
    for (int x = 0; x < TN; x++) begin
      for (int y = 0; y < TN; y++) begin
        if (x >= base && x < base + nb && y >= base && y < base + nb) begin
          // tile is signed when it touches a signed top byte
          ext  = (sg2 && x == base + nb - 1) || (sg1 && y == base + nb - 1);
          term = {{48{ext & p[z*TN*TN + y*TN + x][15]}}, p[z*TN*TN + y*TN + x]};
          acc  = acc + (term << (8 * ((x - base) + (y - base))));
        end
      end
    end
    return acc;
  endfunction

  // {sat flag, element data in low sew bits}
  function automatic logic [32:0] elem_out(logic [63:0] full, int sew,
                                           mul_op_e op, mul_xrm_e xrm);
    logic [63:0] mask;
    logic        lsb;
    logic        half;
    logic        sticky;
    logic        incr;
    logic        sat;
    logic [63:0] res;
    mask   = (64'd1 << sew) - 64'd1;
    lsb    = full[sew-1];                                  // lsb after >> sew-1
    half   = full[sew-2];
    sticky = |(full & ((64'd1 << (sew - 2)) - 64'd1));
    sat    = (full[2*sew-1 -: 2] == 2'b01);                // only -min * -min
    case (xrm)
      RNE:     incr = half & (sticky | lsb);
      RDN:     incr = 1'b0;
      ROD:     incr = ~lsb & (half | sticky);
      default: incr = half;                                // RNU
    endcase
    case (op)
      MUL_HIGH_SS, MUL_HIGH_UU, MUL_HIGH_SU: res = full >> sew;
      MUL_SMUL: res = sat ? (mask >> 1) : (full >> (sew - 1)) + 64'(incr);
      default:  res = full;                                // low half
    endcase
    return {sat & (op == MUL_SMUL), res[31:0] & mask[31:0]};
  endfunction

  assign {s2, s1} = op_signs(prod.ctrl.op);

  //////////////////////////////
  // per-eew element results
  //////////////////////////////

  always_comb begin
    logic [63:0] full;
    logic [32:0] r;
    sat8  = '0;
    sat16 = '0;
    sat32 = '0;
    for (int z = 0; z < GROUPS; z++) begin
      // eew8 uses the diagonal tiles
      for (int e = 0; e < TN; e++) begin
        full = elem_prod(prod.parts, z, e, 1, s2, s1);
        r    = elem_out(full, 8, prod.ctrl.op, prod.ctrl.xrm);
        data8[8*(z*TN+e) +: 8] = r[7:0];
        sat8[z*TN+e]           = r[32];
      end
      // eew16 uses the 2x2 blocks on the diagonal
      for (int e = 0; e < TN/2; e++) begin
        full = elem_prod(prod.parts, z, 2*e, 2, s2, s1);
        r    = elem_out(full, 16, prod.ctrl.op, prod.ctrl.xrm);
        data16[16*(z*2+e) +: 16] = r[15:0];
        sat16[z*TN+2*e+1]        = r[32];   // flag on the top byte
      end
      // eew32 uses the whole group
      full = elem_prod(prod.parts, z, 0, TN, s2, s1);
      r    = elem_out(full, 32, prod.ctrl.op, prod.ctrl.xrm);
      data32[32*z +: 32] = r[31:0];
      sat32[z*TN+TN-1]   = r[32];
    end
  end

  //////////////////////////////
  // output select
  //////////////////////////////

  always_comb begin
    case (prod.ctrl.eew)
      EEW16: begin
        out_data = data16;
        out_vsat = sat16;
      end
      EEW32: begin
        out_data = data32;
        out_vsat = sat32;
      end
      default: begin
        out_data = data8;
        out_vsat = sat8;
      end
    endcase
  end

  assign out_valid = prod.valid;
  assign out_tag   = prod.ctrl.tag;

endmodule

/* source/mul_unit.sv */
/*
  Vector integer multiply unit
  One-stage pipeline: decode and tile multiply, register, then assemble.
  Results leave one clock after the uop is taken, with its tag.
*/
`timescale 1ns/1ps

module mul_unit import mul_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     valid,
  input  mul_op_e  op,
  input  mul_eew_e eew,
  input  mul_xrm_e xrm,
  input  logic     scalar,
  input  vreg_t    vs2,
  input  vreg_t    vs1,
  input  xreg_t    rs1,
  input  tag_t     tag,
  output logic     out_valid,
  output tag_t     out_tag,
  output vreg_t    out_data,
  output vsat_t    out_vsat
);

  mul_op_if   op_bus ();    // decode to tiles
  mul_prod_if prod_bus ();  // register to result

  mul_decode u_decode (
    .valid  (valid),
    .op     (op),
    .eew    (eew),
    .xrm    (xrm),
    .scalar (scalar),
    .vs2    (vs2),
    .vs1    (vs1),
    .rs1    (rs1),
    .tag    (tag),
    .dec    (op_bus)
  );

  mul_array u_array (
    .clk    (clk),
    .arst_n (arst_n),
    .opr    (op_bus),
    .prod   (prod_bus)
  );

  mul_result u_result (
    .prod      (prod_bus),
    .out_valid (out_valid),
    .out_tag   (out_tag),
    .out_data  (out_data),
    .out_vsat  (out_vsat)
  );

endmodule

/* verification/tb_clock_gen.sv */
/*
  Testbench clock and reset
  Free-running clock, reset held low for a fixed number of cycles.
*/
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;   // release away from the edge
  end

endmodule

/* verification/mul_unit_asserts.sv */
/*
  Protocol checks for the multiply unit
  Valid timing, saturation flags and known data, bound into the top level.
*/
`timescale 1ns/1ps

module mul_unit_asserts import mul_pkg::*; (
  input logic    clk,
  input logic    arst_n,
  input logic    valid,
  input mul_op_e op,
  input logic    out_valid,
  input vreg_t   out_data,
  input vsat_t   out_vsat
);

  int fails = 0;   // failed assertions so far

  a_valid_pipe: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(valid))
    else begin
      $error("out_valid does not follow valid of the previous cycle");
      fails++;
    end

  a_vsat_smul: assert property (@(posedge clk) disable iff (!arst_n)
    $past(op) != MUL_SMUL |-> out_vsat == '0)
    else begin
      $error("saturation flags set for an op other than vsmul");
      fails++;
    end

  a_data_known: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !$isunknown(out_data))
    else begin
      $error("unknown bits in out_data while out_valid is high");
      fails++;
    end

  a_reset_idle: assert property (@(negedge clk) !arst_n |-> !out_valid)
    else begin
      $error("out_valid high during reset");
      fails++;
    end

endmodule

bind mul_unit mul_unit_asserts u_asserts (
  .clk       (clk),
  .arst_n    (arst_n),
  .valid     (valid),
  .op        (op),
  .out_valid (out_valid),
  .out_data  (out_data),
  .out_vsat  (out_vsat)
);

/* verification/tb_mul_unit.sv */
/*
  Testbench for the vector multiply unit
  Random uops from an xorshift source, checked per element against a model.
*/
`timescale 1ns/1ps
`include "mul_defines.svh"

module tb_mul_unit import mul_pkg::*; ();

  localparam int N_OPS   = 200;
  localparam int N_TESTS = 6;
  localparam int LIMIT   = N_TESTS * N_OPS + 200;   // cycles

  typedef struct packed {
    tag_t  tag;
    vreg_t data;
    vsat_t vsat;
  } expect_t;

  logic     clk;
  logic     arst_n;
  logic     valid;
  mul_op_e  op;
  mul_eew_e eew;
  mul_xrm_e xrm;
  logic     scalar;
  vreg_t    vs2;
  vreg_t    vs1;
  xreg_t    rs1;
  tag_t     tag;
  logic     out_valid;
  tag_t     out_tag;
  vreg_t    out_data;
  vsat_t    out_vsat;

  expect_t     exp_q[$];
  logic [31:0] rng_state = 32'd62;
  string       test_name = "reset";
  int          errors = 0;
  int          checks = 0;
  int          err_start = 0;
  int          tests_done = 0;
  int          cycles = 0;

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(8)) u_clk (.clk(clk), .arst_n(arst_n));

  mul_unit DUT (.*);

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic vreg_t rand_vec();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  function automatic int sew_of(mul_eew_e e);
    case (e)
      EEW16:   return 16;
      EEW32:   return 32;
      default: return 8;
    endcase
  endfunction

  function automatic logic [31:0] elem_mask(int sew);
    logic [63:0] m;
    m = (64'd1 << sew) - 64'd1;
    return m[31:0];
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  // {sat, data} of one element from the exact signed product
  function automatic logic [32:0] golden_elem(mul_op_e o, int sew, mul_xrm_e x,
                                              logic [31:0] a, logic [31:0] b);
    logic signed [65:0] pa;
    logic signed [65:0] pb;
    logic signed [65:0] p;
    logic signed [65:0] q;
    logic [31:0]        m;
    logic [31:0]        mn;
    logic               lsb;
    logic               half;
    logic               sticky;
    logic               inc;
    int                 d;
    m  = elem_mask(sew);
    mn = 32'd1 << (sew - 1);
    d  = sew - 1;
    pa = {34'd0, a};
    pb = {34'd0, b};
    if (o != MUL_HIGH_UU && a[sew-1]) pa = pa - (66'sd1 << sew);
    if (o != MUL_HIGH_UU && o != MUL_HIGH_SU && b[sew-1]) pb = pb - (66'sd1 << sew);
    p      = pa * pb;
    q      = p >>> d;
    lsb    = p[d];
    half   = p[d-1];
    sticky = |(p & ((66'sd1 << (d - 1)) - 66'sd1));
    case (x)
      RNU:     inc = half;
      RNE:     inc = half & (sticky | lsb);
      RDN:     inc = 1'b0;
      default: inc = ~lsb & (half | sticky);   // round to odd
    endcase
    case (o)
      MUL_HIGH_SS, MUL_HIGH_UU, MUL_HIGH_SU: return {1'b0, 32'(p >>> sew) & m};
      MUL_SMUL: begin
        if (a == mn && b == mn) return {1'b1, m >> 1};
        return {1'b0, (32'(q) + 32'(inc)) & m};
      end
      default: return {1'b0, 32'(p) & m};
    endcase
  endfunction

  task automatic predict(input mul_op_e o, input mul_eew_e e, input mul_xrm_e x,
                         input logic sc, input vreg_t a, input vreg_t b, input xreg_t s,
                         output vreg_t data, output vsat_t vsat);
    int          sew;
    logic [31:0] m;
    logic [32:0] r;
    sew  = sew_of(e);
    m    = elem_mask(sew);
    data = '0;
    vsat = '0;
    for (int i = 0; i < `MUL_VLEN / sew; i++) begin
      r = golden_elem(o, sew, x, 32'(a >> (i * sew)) & m,
                      sc ? (s & m) : (32'(b >> (i * sew)) & m));
      data = data | (vreg_t'(r[31:0]) << (i * sew));
      if (r[32]) vsat[i * sew / 8 + sew / 8 - 1] = 1'b1;   // top byte of element
    end
  endtask

  // puts -min into both operands of random elements or breaks any -min pairs
  task automatic min_pairs(input mul_eew_e e, input logic force_some,
                           inout vreg_t a, inout vreg_t b);
    int          sew;
    logic [31:0] m;
    logic [31:0] mn;
    sew = sew_of(e);
    m   = elem_mask(sew);
    mn  = 32'd1 << (sew - 1);
    for (int sh = 0; sh < `MUL_VLEN; sh += sew) begin
      if (force_some && next_rand() % 2 == 1) begin
        a = (a & ~(vreg_t'(m) << sh)) | (vreg_t'(mn) << sh);
        b = (b & ~(vreg_t'(m) << sh)) | (vreg_t'(mn) << sh);
      end else if (!force_some && ((a >> sh) & m) == mn && ((b >> sh) & m) == mn) begin
        b = b ^ (vreg_t'(1) << sh);
      end
    end
  endtask

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_data(vreg_t exp, vreg_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch in %s: data expected %h, actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_vsat(vsat_t exp, vsat_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch in %s: vsat expected %h, actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_tag(tag_t exp, tag_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch in %s: tag expected %h, actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_valid(logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      if (exp)
        $display("Error in %s: a result did not appear one cycle after its uop", test_name);
      else
        $display("Error in %s: out_valid was high with no uop accepted", test_name);
    end
  endtask

  //////////////////////////////
  // driver and monitor
  //////////////////////////////

  task automatic issue(mul_op_e o, mul_eew_e e, mul_xrm_e x, logic sc,
                       vreg_t a, vreg_t b, xreg_t s);
    expect_t ex;
    @(posedge clk);
    #1;
    valid  = 1'b1;
    op     = o;
    eew    = e;
    xrm    = x;
    scalar = sc;
    vs2    = a;
    vs1    = b;
    rs1    = s;
    tag    = tag_t'(next_rand());
    ex.tag = tag;
    predict(o, e, x, sc, a, b, s, ex.data, ex.vsat);
    exp_q.push_back(ex);
  endtask

  task automatic idle();
    @(posedge clk);
    #1 valid = 1'b0;
  endtask

  task automatic start_test(string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic finish_test(int n);
    idle();
    while (exp_q.size() != 0) @(negedge clk);   // last result drained
    tests_done++;
    $display("test %s done: %0d uops, %0d errors", test_name, n, errors - err_start);
  endtask

  initial begin
    logic    exp_valid;
    expect_t ex;
    exp_valid = 1'b0;
    @(posedge clk);
    forever begin
      @(negedge clk);
      check_valid(exp_valid, out_valid);
      if (exp_valid) begin
        ex = exp_q.pop_front();
        if (out_valid === 1'b1) begin
          check_tag(ex.tag, out_tag);
          check_data(ex.data, out_data);
          check_vsat(ex.vsat, out_vsat);
        end
      end
      exp_valid = arst_n & valid;   // taken at the coming edge
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    vreg_t    a;
    vreg_t    b;
    mul_eew_e e;
    int       total;
    valid  = 1'b0;
    op     = MUL_LOW;
    eew    = EEW8;
    xrm    = RNU;
    scalar = 1'b0;
    vs2    = '0;
    vs1    = '0;
    rs1    = '0;
    tag    = '0;
    @(posedge arst_n);

    start_test("low_vv");
    for (int i = 0; i < N_OPS; i++)
      issue(MUL_LOW, mul_eew_e'(2'(i % 3)), RNU, 1'b0, rand_vec(), rand_vec(), '0);
    finish_test(N_OPS);

    start_test("high_vv");
    for (int i = 0; i < N_OPS; i++)
      issue(mul_op_e'(3'(1 + i % 3)), mul_eew_e'(2'((i / 3) % 3)), RNU, 1'b0,
            rand_vec(), rand_vec(), '0);
    finish_test(N_OPS);

    start_test("scalar_vx");
    for (int i = 0; i < N_OPS; i++)
      issue(mul_op_e'(3'(i % 4)), mul_eew_e'(2'(next_rand() % 3)), RNU, 1'b1,
            rand_vec(), rand_vec(), next_rand());
    finish_test(N_OPS);

    start_test("smul_round");
    for (int i = 0; i < N_OPS; i++) begin
      e = mul_eew_e'(2'(next_rand() % 3));
      a = rand_vec();
      b = rand_vec();
      min_pairs(e, 1'b0, a, b);
      issue(MUL_SMUL, e, mul_xrm_e'(2'(i % 4)), 1'b0, a, b, '0);
    end
    finish_test(N_OPS);

    start_test("smul_sat");
    for (int i = 0; i < N_OPS; i++) begin
      e = mul_eew_e'(2'(next_rand() % 3));
      a = rand_vec();
      b = rand_vec();
      min_pairs(e, 1'b1, a, b);
      issue(MUL_SMUL, e, mul_xrm_e'(2'(next_rand())), 1'b0, a, b, '0);
    end
    finish_test(N_OPS);

    start_test("pipeline");
    for (int i = 0; i < N_OPS / 2; i++) begin
      repeat (next_rand() % 2) idle();   // random gap
      issue(mul_op_e'(3'(next_rand() % 5)), mul_eew_e'(2'(next_rand() % 3)),
            mul_xrm_e'(2'(next_rand())), 1'(next_rand()), rand_vec(), rand_vec(), next_rand());
    end
    finish_test(N_OPS / 2);

    total = errors + DUT.u_asserts.fails;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_done, checks, errors, DUT.u_asserts.fails);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* Bender.yml */
package:
  name: mul_unit

export_include_dirs:
  - source

sources:
  - files:
      - source/mul_pkg.sv
      - source/mul_stage_if.sv
      - source/mul_decode.sv
      - source/mul_array.sv
      - source/mul_result.sv
      - source/mul_unit.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/mul_unit_asserts.sv
      - verification/tb_mul_unit.sv

/* all.f */
+incdir+source
source/mul_pkg.sv
source/mul_stage_if.sv
source/mul_decode.sv
source/mul_array.sv
source/mul_result.sv
source/mul_unit.sv
verification/tb_clock_gen.sv
verification/mul_unit_asserts.sv
verification/tb_mul_unit.sv
